/* hw/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    localparam int NUM_REGS   = 32;
    localparam int REG_W      = 5;
    localparam int ROB_DEPTH  = 8;
    localparam int ROB_ID_W   = 4;
    localparam int ROB_PTR_W  = $clog2(ROB_DEPTH);
    localparam int DATA_W     = 32;
    localparam int APB_ADDR_W = 12;

    typedef logic [REG_W-1:0]      reg_idx_t;
    typedef logic [ROB_ID_W-1:0]   rob_id_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;

    // register 0 is hardwired to zero
    localparam reg_idx_t ZERO_REG = '0;
    // tag k names rob slot k-1
    localparam rob_id_t  NO_TAG   = '0;

    localparam apb_addr_t CSR_CTRL_ADDR    = 12'h000;
    localparam apb_addr_t CSR_STATUS_ADDR  = 12'h004;
    localparam apb_addr_t CSR_COMMITS_ADDR = 12'h008;

endpackage

`default_nettype wire

/* hw/reg_status_file.sv */
`default_nettype none
`timescale 1ns/100ps

module reg_status_file (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 flush,

    // read ports
    input  rename_pkg::reg_idx_t rs1,
    input  rename_pkg::reg_idx_t rs2,
    output rename_pkg::data_t    v1,
    output rename_pkg::data_t    v2,
    output rename_pkg::rob_id_t  q1,
    output rename_pkg::rob_id_t  q2,

    // allocation from dispatch
    input  wire                  alloc_en,
    input  rename_pkg::reg_idx_t alloc_rd,
    input  rename_pkg::rob_id_t  alloc_tag,

    // commit from rob
    input  wire                  cmt_valid,
    input  rename_pkg::reg_idx_t cmt_rd,
    input  rename_pkg::rob_id_t  cmt_tag,
    input  rename_pkg::data_t    cmt_value
);

    import rename_pkg::*;

    data_t   values [NUM_REGS];
    rob_id_t tags   [NUM_REGS];
    logic    tag_in_use;

    assign v1 = values[rs1];
    assign v2 = values[rs2];
    assign q1 = tags[rs1];
    assign q2 = tags[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                values[i] <= '0;
                tags[i]   <= NO_TAG;
            end
        end else begin
            if (cmt_valid && cmt_rd != ZERO_REG) begin
                values[cmt_rd] <= cmt_value;
                // a younger producer keeps its tag
                if (tags[cmt_rd] == cmt_tag) begin
                    tags[cmt_rd] <= NO_TAG;
                end
            end

            // flush overrides alloc and alloc overrides the commit clear
            if (flush) begin
                for (int i = 0; i < NUM_REGS; i++) begin
                    tags[i] <= NO_TAG;
                end
            end else if (alloc_en && alloc_rd != ZERO_REG) begin
                tags[alloc_rd] <= alloc_tag;
            end
        end
    end

    // a reused tag must have left every register
    always_comb begin
        tag_in_use = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (tags[i] == alloc_tag) begin
                tag_in_use = 1'b1;
            end
        end
    end

    a_alloc_tag_free: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc_en |-> !tag_in_use
    ) else $error("allocated tag is still held by a register");

endmodule

`default_nettype wire

/* hw/reorder_buffer.sv */
`default_nettype none
`timescale 1ns/100ps

module reorder_buffer (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  flush,

    // allocation
    input  wire                  alloc_en,
    input  rename_pkg::reg_idx_t alloc_rd,
    output rename_pkg::rob_id_t  alloc_tag,
    output logic                 full,
    output rename_pkg::rob_id_t  occupancy,

    // completion bus
    input  wire                  cdb_valid,
    input  rename_pkg::rob_id_t  cdb_tag,
    input  rename_pkg::data_t    cdb_value,

    // operand lookup
    input  rename_pkg::rob_id_t  lk_tag1,
    input  rename_pkg::rob_id_t  lk_tag2,
    output logic                 lk_done1,
    output rename_pkg::data_t    lk_value1,
    output logic                 lk_done2,
    output rename_pkg::data_t    lk_value2,

    // commit
    output logic                 cmt_valid,
    output rename_pkg::reg_idx_t cmt_rd,
    output rename_pkg::rob_id_t  cmt_tag,
    output rename_pkg::data_t    cmt_value
);

    import rename_pkg::*;

    logic                 busy        [ROB_DEPTH];
    logic                 done        [ROB_DEPTH];
    reg_idx_t             entry_rd    [ROB_DEPTH];
    data_t                entry_value [ROB_DEPTH];

    logic [ROB_PTR_W-1:0] head;
    logic [ROB_PTR_W-1:0] tail;
    rob_id_t              count;

    logic [ROB_PTR_W-1:0] cdb_slot;
    logic [ROB_PTR_W-1:0] lk_slot1;
    logic [ROB_PTR_W-1:0] lk_slot2;
    logic                 cmt_fire;

    function automatic logic [ROB_PTR_W-1:0] tag_slot(input rob_id_t tag);
        rob_id_t idx;
        idx = tag - rob_id_t'(1);
        return idx[ROB_PTR_W-1:0];
    endfunction

    assign alloc_tag = rob_id_t'(tail) + rob_id_t'(1);
    assign full      = (count == rob_id_t'(ROB_DEPTH));
    assign occupancy = count;

    assign cdb_slot = tag_slot(cdb_tag);
    assign lk_slot1 = tag_slot(lk_tag1);
    assign lk_slot2 = tag_slot(lk_tag2);

    assign lk_done1  = (lk_tag1 != NO_TAG) && busy[lk_slot1] && done[lk_slot1];
    assign lk_value1 = entry_value[lk_slot1];
    assign lk_done2  = (lk_tag2 != NO_TAG) && busy[lk_slot2] && done[lk_slot2];
    assign lk_value2 = entry_value[lk_slot2];

    // in-order retire from the head
    assign cmt_fire  = busy[head] && done[head] && !flush;
    assign cmt_valid = cmt_fire;
    assign cmt_rd    = entry_rd[head];
    assign cmt_tag   = rob_id_t'(head) + rob_id_t'(1);
    assign cmt_value = entry_value[head];

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                busy[i] <= 1'b0;
                done[i] <= 1'b0;
            end
        end else begin
            if (cdb_valid) begin
                done[cdb_slot] <= 1'b1;
            end
            if (cmt_fire) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            // tail slot is free here, so no clash with the head pop
            if (alloc_en) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            count <= count + rob_id_t'(alloc_en) - rob_id_t'(cmt_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            entry_rd[tail] <= alloc_rd;
        end
        if (cdb_valid && !flush) begin
            entry_value[cdb_slot] <= cdb_value;
        end
    end

    a_cdb_to_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        cdb_valid |-> (cdb_tag != NO_TAG && busy[cdb_slot] && !done[cdb_slot])
    ) else $error("completion for a tag that is not in flight");

    // dispatch must honour full
    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc_en |-> !full
    ) else $error("allocation while rob is full");

endmodule

`default_nettype wire

/* hw/dispatch_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module dispatch_unit (
    input  wire                  clk,
    input  wire                  rst_n,

    // decoded instruction
    input  wire                  dsp_valid,
    output logic                 dsp_ready,
    input  rename_pkg::reg_idx_t dsp_rd,
    input  rename_pkg::reg_idx_t dsp_rs1,
    input  rename_pkg::reg_idx_t dsp_rs2,

    input  wire                  enable,
    input  wire                  flush,
    input  wire                  rob_full,

    // register status read
    input  rename_pkg::data_t    rf_v1,
    input  rename_pkg::data_t    rf_v2,
    input  rename_pkg::rob_id_t  rf_q1,
    input  rename_pkg::rob_id_t  rf_q2,

    // rob lookup
    output rename_pkg::rob_id_t  lk_tag1,
    output rename_pkg::rob_id_t  lk_tag2,
    input  wire                  lk_done1,
    input  rename_pkg::data_t    lk_value1,
    input  wire                  lk_done2,
    input  rename_pkg::data_t    lk_value2,

    // same-cycle completion bypass
    input  wire                  cdb_valid,
    input  rename_pkg::rob_id_t  cdb_tag,
    input  rename_pkg::data_t    cdb_value,

    // allocation
    input  rename_pkg::rob_id_t  free_tag,
    output logic                 alloc_en,
    output rename_pkg::reg_idx_t alloc_rd,
    output rename_pkg::rob_id_t  alloc_tag,

    // issue packet
    output logic                 iss_valid,
    output rename_pkg::rob_id_t  iss_tag,
    output rename_pkg::data_t    iss_v1,
    output rename_pkg::rob_id_t  iss_q1,
    output rename_pkg::data_t    iss_v2,
    output rename_pkg::rob_id_t  iss_q2
);

    import rename_pkg::*;

    logic    accept;
    data_t   res_v1;
    data_t   res_v2;
    rob_id_t res_q1;
    rob_id_t res_q2;

    // rf value, then rob result, then cdb, else wait on the tag
    function automatic void resolve(
        input  rob_id_t q,
        input  data_t   rf_v,
        input  logic    rob_done,
        input  data_t   rob_v,
        input  logic    bus_valid,
        input  rob_id_t bus_tag,
        input  data_t   bus_v,
        output data_t   val,
        output rob_id_t tag
    );
        val = '0;
        tag = NO_TAG;
        if (q == NO_TAG) begin
            val = rf_v;
        end else if (rob_done) begin
            val = rob_v;
        end else if (bus_valid && bus_tag == q) begin
            val = bus_v;
        end else begin
            tag = q;
        end
    endfunction

    assign dsp_ready = enable && !flush && !rob_full;
    assign accept    = dsp_valid && dsp_ready;

    assign alloc_en  = accept;
    assign alloc_rd  = dsp_rd;
    assign alloc_tag = free_tag;

    assign lk_tag1 = rf_q1;
    assign lk_tag2 = rf_q2;

    always_comb begin
        resolve(rf_q1, rf_v1, lk_done1, lk_value1, cdb_valid, cdb_tag, cdb_value,
                res_v1, res_q1);
        resolve(rf_q2, rf_v2, lk_done2, lk_value2, cdb_valid, cdb_tag, cdb_value,
                res_v2, res_q2);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            iss_tag <= free_tag;
            iss_v1  <= res_v1;
            iss_q1  <= res_q1;
            iss_v2  <= res_v2;
            iss_q2  <= res_q2;
        end
    end

endmodule

`default_nettype wire

/* hw/rename_csr.sv */
`default_nettype none
`timescale 1ns/100ps

module rename_csr (
    input  wire                   clk,
    input  wire                   rst_n,

    // apb slave
    input  wire                   psel,
    input  wire                   penable,
    input  wire                   pwrite,
    input  rename_pkg::apb_addr_t paddr,
    input  rename_pkg::data_t     pwdata,
    output rename_pkg::data_t     prdata,
    output logic                  pready,
    output logic                  pslverr,

    // core side
    input  wire                   commit_pulse,
    input  rename_pkg::rob_id_t   occupancy,
    output logic                  core_enable,
    output logic                  flush
);

    import rename_pkg::*;

    logic  access;
    logic  addr_hit;
    logic  wr_en;
    data_t commit_cnt;

    assign access   = psel && penable;
    assign addr_hit = (paddr == CSR_CTRL_ADDR) || (paddr == CSR_STATUS_ADDR) ||
                      (paddr == CSR_COMMITS_ADDR);
    assign wr_en    = access && pwrite && addr_hit;

    // zero wait states
    assign pready  = 1'b1;
    assign pslverr = access && !addr_hit;

    always_comb begin
        case (paddr)
            CSR_CTRL_ADDR:    prdata = data_t'(core_enable);
            CSR_STATUS_ADDR:  prdata = data_t'(occupancy);
            CSR_COMMITS_ADDR: prdata = commit_cnt;
            default:          prdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            core_enable <= 1'b0;
            flush       <= 1'b0;
        end else begin
            // flush bit is write-one, never stored
            flush <= wr_en && (paddr == CSR_CTRL_ADDR) && pwdata[1];
            if (wr_en && paddr == CSR_CTRL_ADDR) begin
                core_enable <= pwdata[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_cnt <= '0;
        end else if (wr_en && paddr == CSR_COMMITS_ADDR) begin
            commit_cnt <= '0;
        end else if (commit_pulse) begin
            commit_cnt <= commit_cnt + 1'b1;
        end
    end

    // error only in an access phase that followed a proper setup phase
    a_slverr_access: assert property (
        @(posedge clk) disable iff (!rst_n)
        pslverr |-> (penable && $past(psel && !penable))
    ) else $error("pslverr outside an apb access phase");

endmodule

`default_nettype wire

/* hw/rename_core_top.sv */
`default_nettype none
`timescale 1ns/100ps

module rename_core_top (
    input  wire                   clk,
    input  wire                   rst_n,

    // apb
    input  wire                   psel,
    input  wire                   penable,
    input  wire                   pwrite,
    input  rename_pkg::apb_addr_t paddr,
    input  rename_pkg::data_t     pwdata,
    output rename_pkg::data_t     prdata,
    output logic                  pready,
    output logic                  pslverr,

    // dispatch
    input  wire                   dsp_valid,
    output logic                  dsp_ready,
    input  rename_pkg::reg_idx_t  dsp_rd,
    input  rename_pkg::reg_idx_t  dsp_rs1,
    input  rename_pkg::reg_idx_t  dsp_rs2,

    // issue
    output logic                  iss_valid,
    output rename_pkg::rob_id_t   iss_tag,
    output rename_pkg::data_t     iss_v1,
    output rename_pkg::rob_id_t   iss_q1,
    output rename_pkg::data_t     iss_v2,
    output rename_pkg::rob_id_t   iss_q2,

    // completion bus
    input  wire                   cdb_valid,
    input  rename_pkg::rob_id_t   cdb_tag,
    input  rename_pkg::data_t     cdb_value,

    // commit trace
    output logic                  cmt_valid,
    output rename_pkg::reg_idx_t  cmt_rd,
    output rename_pkg::rob_id_t   cmt_tag,
    output rename_pkg::data_t     cmt_value
);

    import rename_pkg::*;

    logic     core_enable;
    logic     flush;
    rob_id_t  occupancy;
    logic     rob_full;
    rob_id_t  free_tag;

    logic     alloc_en;
    reg_idx_t alloc_rd;
    rob_id_t  alloc_tag;

    data_t    rf_v1;
    data_t    rf_v2;
    rob_id_t  rf_q1;
    rob_id_t  rf_q2;

    rob_id_t  lk_tag1;
    rob_id_t  lk_tag2;
    logic     lk_done1;
    logic     lk_done2;
    data_t    lk_value1;
    data_t    lk_value2;

    rename_csr u_csr (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .commit_pulse (cmt_valid),
        .occupancy    (occupancy),
        .core_enable  (core_enable),
        .flush        (flush)
    );

    dispatch_unit u_dispatch (
        .clk       (clk),
        .rst_n     (rst_n),
        .dsp_valid (dsp_valid),
        .dsp_ready (dsp_ready),
        .dsp_rd    (dsp_rd),
        .dsp_rs1   (dsp_rs1),
        .dsp_rs2   (dsp_rs2),
        .enable    (core_enable),
        .flush     (flush),
        .rob_full  (rob_full),
        .rf_v1     (rf_v1),
        .rf_v2     (rf_v2),
        .rf_q1     (rf_q1),
        .rf_q2     (rf_q2),
        .lk_tag1   (lk_tag1),
        .lk_tag2   (lk_tag2),
        .lk_done1  (lk_done1),
        .lk_value1 (lk_value1),
        .lk_done2  (lk_done2),
        .lk_value2 (lk_value2),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .free_tag  (free_tag),
        .alloc_en  (alloc_en),
        .alloc_rd  (alloc_rd),
        .alloc_tag (alloc_tag),
        .iss_valid (iss_valid),
        .iss_tag   (iss_tag),
        .iss_v1    (iss_v1),
        .iss_q1    (iss_q1),
        .iss_v2    (iss_v2),
        .iss_q2    (iss_q2)
    );

    // source indices go straight to the read ports
    reg_status_file u_rsf (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .rs1       (dsp_rs1),
        .rs2       (dsp_rs2),
        .v1        (rf_v1),
        .v2        (rf_v2),
        .q1        (rf_q1),
        .q2        (rf_q2),
        .alloc_en  (alloc_en),
        .alloc_rd  (alloc_rd),
        .alloc_tag (alloc_tag),
        .cmt_valid (cmt_valid),
        .cmt_rd    (cmt_rd),
        .cmt_tag   (cmt_tag),
        .cmt_value (cmt_value)
    );

    reorder_buffer u_rob (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .alloc_en  (alloc_en),
        .alloc_rd  (alloc_rd),
        .alloc_tag (free_tag),
        .full      (rob_full),
        .occupancy (occupancy),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .lk_tag1   (lk_tag1),
        .lk_tag2   (lk_tag2),
        .lk_done1  (lk_done1),
        .lk_value1 (lk_value1),
        .lk_done2  (lk_done2),
        .lk_value2 (lk_value2),
        .cmt_valid (cmt_valid),
        .cmt_rd    (cmt_rd),
        .cmt_tag   (cmt_tag),
        .cmt_value (cmt_value)
    );

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int RESET_CYCLES = 3;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* dv/rename_core_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module rename_core_tb;

    import rename_pkg::*;

    localparam int N_RANDOM   = 500;
    localparam int N_BP       = 12;
    localparam int N_FLUSH    = 16;
    localparam int N_APB      = 20;
    // every instruction also needs one completion
    localparam int TOTAL_OPS  = 2 * (N_RANDOM + N_BP + N_FLUSH) + N_APB;
    localparam int MAX_CYCLES = 4 * TOTAL_OPS + 200;

    logic      clk, rst_n;
    logic      psel, penable, pwrite, pready, pslverr;
    apb_addr_t paddr;
    data_t     pwdata, prdata;
    logic      dsp_valid, dsp_ready;
    reg_idx_t  dsp_rd, dsp_rs1, dsp_rs2;
    logic      iss_valid;
    rob_id_t   iss_tag, iss_q1, iss_q2;
    data_t     iss_v1, iss_v2;
    logic      cdb_valid;
    rob_id_t   cdb_tag;
    data_t     cdb_value;
    logic      cmt_valid;
    reg_idx_t  cmt_rd;
    rob_id_t   cmt_tag;
    data_t     cmt_value;

    // reference model state
    data_t    m_val [NUM_REGS];
    rob_id_t  m_tag [NUM_REGS];
    rob_id_t  q_tag [$];
    reg_idx_t q_rd [$];
    logic     q_done [$];
    data_t    q_val [$];
    rob_id_t  next_tag = rob_id_t'(1);
    logic     m_enable = 1'b0;
    logic     m_flush = 1'b0;
    data_t    m_commits = '0;

    // packet expected on the issue port in the next cycle
    logic     e_valid = 1'b0;
    rob_id_t  e_tag, e_q1, e_q2;
    data_t    e_v1, e_v2;

    logic     last_accept;
    data_t    apb_rdata;
    int       cycles = 0;
    int       n_accepted = 0;
    int       n_issued = 0;
    int       n_committed = 0;
    int       n_flushed = 0;
    int       n_self = 0;
    int       n_zero = 0;
    int       n_bypass = 0;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rename_core_top DUT (.*);

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at cycle %0d", cycles);
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        compare_word(name, got, exp);
    endtask

    task automatic check_issue(input rob_id_t tag, input data_t v1, input rob_id_t q1,
                               input data_t v2, input rob_id_t q2);
        compare_word("iss_tag", iss_tag, tag);
        compare_word("iss_v1", iss_v1, v1);
        compare_word("iss_q1", iss_q1, q1);
        compare_word("iss_v2", iss_v2, v2);
        compare_word("iss_q2", iss_q2, q2);
    endtask

    task automatic check_commit(input reg_idx_t rd, input rob_id_t tag, input data_t value);
        compare_word("cmt_rd", cmt_rd, rd);
        compare_word("cmt_tag", cmt_tag, tag);
        compare_word("cmt_value", cmt_value, value);
    endtask

    task automatic check_apb(input string name, input data_t got, input data_t exp);
        compare_word(name, got, exp);
    endtask

    function automatic logic is_mapped(input apb_addr_t addr);
        return addr == CSR_CTRL_ADDR || addr == CSR_STATUS_ADDR || addr == CSR_COMMITS_ADDR;
    endfunction

    function automatic int find_entry(input rob_id_t tag);
        foreach (q_tag[i]) begin
            if (q_tag[i] == tag) return i;
        end
        return -1;
    endfunction

    // model operand, looked up in rf then rob then cdb order
    task automatic resolve_src(input reg_idx_t rs, output data_t v, output rob_id_t q);
        int idx;
        v = '0;
        q = m_tag[rs];
        idx = find_entry(q);
        if (q == NO_TAG) begin
            v = m_val[rs];
        end else if (idx >= 0 && q_done[idx]) begin
            v = q_val[idx];
            q = NO_TAG;
        end else if (cdb_valid && cdb_tag == q) begin
            v = cdb_value;
            q = NO_TAG;
            n_bypass++;
        end
    endtask

    // one clock with checks at the falling edge and model update at the rising edge
    task automatic tick();
        logic    flush_now;
        logic    ready_exp;
        logic    cmt_exp;
        logic    csr_wr;
        logic    accept;
        data_t   v1, v2;
        rob_id_t q1, q2;
        int      idx;
        @(negedge clk);
        flush_now = m_flush;
        ready_exp = m_enable && !flush_now && (q_tag.size() < ROB_DEPTH);
        cmt_exp   = !flush_now && q_tag.size() > 0 && q_done[0];
        csr_wr    = psel && penable && pwrite;
        check_flag("dsp_ready", dsp_ready, ready_exp);
        check_flag("iss_valid", iss_valid, e_valid);
        if (e_valid) begin
            check_issue(e_tag, e_v1, e_q1, e_v2, e_q2);
            n_issued++;
        end
        check_flag("cmt_valid", cmt_valid, cmt_exp);
        if (cmt_exp) check_commit(q_rd[0], q_tag[0], q_val[0]);
        check_flag("pready", pready, 1'b1);
        check_flag("pslverr", pslverr, psel && penable && !is_mapped(paddr));
        apb_rdata = prdata;
        accept = dsp_valid && ready_exp;
        if (accept) begin
            resolve_src(dsp_rs1, v1, q1);
            resolve_src(dsp_rs2, v2, q2);
        end

        @(posedge clk);
        e_valid = accept;
        if (accept) begin
            e_tag = next_tag;
            e_v1  = v1;
            e_q1  = q1;
            e_v2  = v2;
            e_q2  = q2;
        end
        if (flush_now) begin
            n_flushed += q_tag.size();
            q_tag.delete();
            q_rd.delete();
            q_done.delete();
            q_val.delete();
            foreach (m_tag[i]) m_tag[i] = NO_TAG;
            next_tag = rob_id_t'(1);
        end else begin
            if (cmt_exp) begin
                if (q_rd[0] != ZERO_REG) begin
                    m_val[q_rd[0]] = q_val[0];
                    if (m_tag[q_rd[0]] == q_tag[0]) m_tag[q_rd[0]] = NO_TAG;
                end
                void'(q_tag.pop_front());
                void'(q_rd.pop_front());
                void'(q_done.pop_front());
                void'(q_val.pop_front());
                n_committed++;
            end
            idx = find_entry(cdb_tag);
            if (cdb_valid && idx >= 0) begin
                q_done[idx] = 1'b1;
                q_val[idx]  = cdb_value;
            end
            if (accept) begin
                q_tag.push_back(next_tag);
                q_rd.push_back(dsp_rd);
                q_done.push_back(1'b0);
                q_val.push_back('0);
                // a younger producer takes over the register
                if (dsp_rd != ZERO_REG) m_tag[dsp_rd] = next_tag;
                next_tag = (next_tag == rob_id_t'(ROB_DEPTH)) ? rob_id_t'(1)
                                                               : next_tag + rob_id_t'(1);
                n_accepted++;
                if (dsp_rs1 == dsp_rd || dsp_rs2 == dsp_rd) n_self++;
                if (dsp_rs1 == ZERO_REG || dsp_rs2 == ZERO_REG) n_zero++;
            end
        end
        if (csr_wr && paddr == CSR_COMMITS_ADDR) begin
            m_commits = '0;
        end else if (cmt_exp) begin
            m_commits++;
        end
        m_flush = csr_wr && paddr == CSR_CTRL_ADDR && pwdata[1];
        if (csr_wr && paddr == CSR_CTRL_ADDR) m_enable = pwdata[0];
        last_accept = accept;

        #2;
        cycles++;
        if (cycles > MAX_CYCLES) begin
            fail_run($sformatf("timeout: run exceeded %0d cycles", MAX_CYCLES));
        end
    endtask

    task automatic apb_write(input apb_addr_t addr, input data_t data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        tick();
        penable = 1'b1;
        tick();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, input string name, input data_t exp);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        tick();
        penable = 1'b1;
        tick();
        psel    = 1'b0;
        penable = 1'b0;
        check_apb(name, apb_rdata, exp);
    endtask

    // small register range so dependencies are frequent
    function automatic reg_idx_t pick_reg();
        case ($urandom % 8)
            0:       return ZERO_REG;
            1:       return reg_idx_t'($urandom);
            default: return reg_idx_t'($urandom % 8);
        endcase
    endfunction

    task automatic present_instr();
        dsp_valid = 1'b1;
        dsp_rd    = pick_reg();
        dsp_rs1   = ($urandom % 5 == 0) ? dsp_rd : pick_reg();
        dsp_rs2   = ($urandom % 5 == 0) ? dsp_rd : pick_reg();
    endtask

    task automatic drive_completion();
        int pend [$];
        int pick;
        int idx;
        cdb_valid = 1'b0;
        foreach (q_done[i]) begin
            if (!q_done[i]) pend.push_back(i);
        end
        if (pend.size() == 0) return;
        pick = pend[$urandom % pend.size()];
        // now and then hit the pending source of the waiting instruction
        idx = find_entry(m_tag[dsp_rs1]);
        if (dsp_valid && idx >= 0 && !q_done[idx] && $urandom % 3 == 0) pick = idx;
        cdb_valid = 1'b1;
        cdb_tag   = q_tag[pick];
        cdb_value = $urandom;
    endtask

    task automatic hold_until_accepted(input bit completions);
        while (dsp_valid) begin
            if (completions) drive_completion();
            else cdb_valid = 1'b0;
            tick();
            if (last_accept) dsp_valid = 1'b0;
        end
        cdb_valid = 1'b0;
    endtask

    task automatic run_random(input int n_instr, input bit completions);
        int remaining;
        remaining = n_instr;
        while (remaining > 0 || dsp_valid) begin
            if (!dsp_valid && remaining > 0 && $urandom % 4 != 0) begin
                present_instr();
                remaining--;
            end
            if (completions && $urandom % 5 < 3) drive_completion();
            else cdb_valid = 1'b0;
            tick();
            if (last_accept) dsp_valid = 1'b0;
        end
        cdb_valid = 1'b0;
    endtask

    task automatic dispatch_one(input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
        dsp_valid = 1'b1;
        dsp_rd    = rd;
        dsp_rs1   = rs1;
        dsp_rs2   = rs2;
        hold_until_accepted(1'b1);
    endtask

    task automatic drain();
        dsp_valid = 1'b0;
        while (q_tag.size() > 0) begin
            if ($urandom % 2 == 0) drive_completion();
            else cdb_valid = 1'b0;
            tick();
        end
        cdb_valid = 1'b0;
        tick();
    endtask

    initial begin
        reg_idx_t flushed_rd [$];
        int       start_count;
        void'($urandom(39));
        foreach (m_val[i]) begin
            m_val[i] = '0;
            m_tag[i] = NO_TAG;
        end
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        dsp_valid = 1'b0;
        dsp_rd    = '0;
        dsp_rs1   = '0;
        dsp_rs2   = '0;
        cdb_valid = 1'b0;
        cdb_tag   = NO_TAG;
        cdb_value = '0;
        wait (rst_n);
        @(posedge clk);
        #2;

        apb_read(CSR_CTRL_ADDR, "CTRL", 32'd0);
        apb_write(CSR_CTRL_ADDR, 32'h1);
        run_random(N_RANDOM, 1'b1);
        drain();

        // rob fills with completions withheld
        start_count = n_accepted;
        present_instr();
        repeat (N_BP) begin
            tick();
            if (last_accept) present_instr();
        end
        if (n_accepted - start_count != ROB_DEPTH) begin
            fail_run("dispatch did not stop after the reorder buffer filled");
        end
        apb_read(CSR_STATUS_ADDR, "STATUS", data_t'(ROB_DEPTH));
        hold_until_accepted(1'b1);
        drain();

        // flush with entries still in flight
        run_random(5, 1'b1);
        run_random(3, 1'b0);
        foreach (q_rd[i]) flushed_rd.push_back(q_rd[i]);
        apb_write(CSR_CTRL_ADDR, 32'h3);
        apb_read(CSR_STATUS_ADDR, "STATUS", 32'd0);
        foreach (flushed_rd[i]) begin
            dispatch_one(ZERO_REG, flushed_rd[i], flushed_rd[(i + 1) % flushed_rd.size()]);
        end
        drain();

        apb_read(CSR_COMMITS_ADDR, "COMMITS", m_commits);
        apb_write(CSR_COMMITS_ADDR, data_t'($urandom));
        apb_read(CSR_COMMITS_ADDR, "COMMITS", 32'd0);
        apb_write(CSR_CTRL_ADDR, 32'h0);
        apb_read(CSR_CTRL_ADDR, "CTRL", 32'd0);
        start_count = n_accepted;
        present_instr();
        repeat (8) tick();
        apb_read(12'h00c, "unmapped", 32'd0);
        apb_write(12'h100, 32'h1);
        if (n_accepted != start_count) begin
            fail_run("an instruction was accepted while the core was disabled");
        end
        apb_write(CSR_CTRL_ADDR, 32'h1);
        hold_until_accepted(1'b1);
        drain();
        apb_read(CSR_COMMITS_ADDR, "COMMITS", m_commits);

        if (n_self == 0 || n_zero == 0 || n_bypass == 0) begin
            fail_run("random stimulus never hit a self, register 0 or bypass source");
        end
        if (n_issued != n_accepted || n_committed + n_flushed != n_accepted) begin
            fail_run("instructions were lost or duplicated between dispatch and commit");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* list.f */
hw/rename_pkg.sv
hw/reg_status_file.sv
hw/reorder_buffer.sv
hw/dispatch_unit.sv
hw/rename_csr.sv
hw/rename_core_top.sv
dv/tb_clock_gen.sv
dv/rename_core_tb.sv

/* Makefile */
# Verilator build and run of the rename core testbench

TOP := rename_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f

# a failing run stops with $$fatal, so the binary's exit status carries the result
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
